/* src/gb_download_pkg.sv */
package gb_download_pkg;

	// Host transfer bus
	localparam int ioctl_addr_w = 25;
	localparam int ioctl_data_w = 16;
	localparam int filetype_w   = 8;

	// File type codes
	// Cartridge matches on the low six bits or on the full alternate code
	localparam logic [5:0]            ft_cart_low = 6'h01;
	localparam logic [filetype_w-1:0] ft_cart_alt = 8'h80;
	localparam logic [filetype_w-1:0] ft_palette  = 8'h03;
	localparam logic [filetype_w-1:0] ft_cheat    = 8'hFF;

	// Colour palette, four 24-bit colours in the top 96 bits
	localparam int palette_w = 128;
	localparam logic [palette_w-1:0] palette_default = 128'h828214517356305A5F1A3B4900000000;

	// Cheat record layout: strobe, flags, address, compare, replace
	localparam int cheat_w          = 129;
	localparam int cheat_strobe_bit = 128;
	localparam int cheat_flags_lsb  = 96;
	localparam int cheat_addr_lsb   = 64;
	localparam int cheat_cmp_lsb    = 32;
	localparam int cheat_repl_lsb   = 0;

	// Byte offsets of each 16-bit word, low word first
	localparam int cheat_offset_w = 4;
	localparam logic [cheat_offset_w-1:0] cheat_offset_flags_lo = 4'd0;
	localparam logic [cheat_offset_w-1:0] cheat_offset_flags_hi = 4'd2;
	localparam logic [cheat_offset_w-1:0] cheat_offset_addr_lo  = 4'd4;
	localparam logic [cheat_offset_w-1:0] cheat_offset_addr_hi  = 4'd6;
	localparam logic [cheat_offset_w-1:0] cheat_offset_cmp_lo   = 4'd8;
	localparam logic [cheat_offset_w-1:0] cheat_offset_cmp_hi   = 4'd10;
	localparam logic [cheat_offset_w-1:0] cheat_offset_repl_lo  = 4'd12;
	localparam logic [cheat_offset_w-1:0] cheat_offset_repl_hi  = 4'd14;

endpackage

/* src/gb_backup_pkg.sv */
package gb_backup_pkg;

	////////////////////
	// SD side
	////////////////////

	// Block number on the SD image
	localparam int lba_w = 32;

	// Word address inside one 512-byte block
	localparam int buff_addr_w = 8;

	////////////////////
	// Save RAM side
	////////////////////

	// Low block number bits on top of the buffer address
	localparam int bk_addr_w = 17;
	localparam int bk_data_w = 16;

	// Index of the last block to transfer
	localparam int ram_mask_w = 8;

	// Block number bits that select a save RAM page
	localparam int bk_page_w = bk_addr_w - buff_addr_w;

	localparam int bk_words = 2 ** bk_addr_w;

endpackage

/* src/download_decoder.sv */
`timescale 1ns/1ps

module download_decoder (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic                                    ioctl_download,
	input  logic                                    ioctl_wr,
	input  logic [gb_download_pkg::ioctl_addr_w-1:0] ioctl_addr,
	input  logic [gb_download_pkg::ioctl_data_w-1:0] ioctl_dout,
	input  logic [gb_download_pkg::filetype_w-1:0]   filetype,
	output logic                                    dl_wr,
	output logic [gb_download_pkg::ioctl_addr_w-1:0] dl_addr,
	output logic [gb_download_pkg::ioctl_data_w-1:0] dl_data,
	output logic                                    cart_active,
	output logic                                    palette_active,
	output logic                                    cheat_active,
	output logic                                    cart_start,
	output logic                                    cart_done
);

	import gb_download_pkg::*;

	logic is_cart;
	logic is_palette;
	logic is_cheat;
	logic cart_prev;

	// File type decode
	always_comb begin
		is_cart    = (filetype[$bits(ft_cart_low)-1:0] == ft_cart_low) ||
		             (filetype == ft_cart_alt);
		is_palette = (filetype == ft_palette);
		is_cheat   = (filetype == ft_cheat);
	end

	// Transfer word and address, one stage behind the host
	always_ff @(posedge clk_sys) begin
		dl_addr <= ioctl_addr;
		dl_data <= ioctl_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wr          <= 1'b0;
			cart_active    <= 1'b0;
			palette_active <= 1'b0;
			cheat_active   <= 1'b0;
			cart_prev      <= 1'b0;
		end else begin
			dl_wr          <= ioctl_wr;
			cart_active    <= ioctl_download & is_cart;
			palette_active <= ioctl_download & is_palette;
			cheat_active   <= ioctl_download & is_cheat;
			cart_prev      <= cart_active;
		end
	end

	// Edges of the cartridge download
	assign cart_start = cart_active & ~cart_prev;
	assign cart_done  = cart_prev & ~cart_active;

endmodule

/* src/palette_loader.sv */
`timescale 1ns/1ps

module palette_loader (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic                                    dl_wr,
	input  logic [gb_download_pkg::ioctl_data_w-1:0] dl_data,
	input  logic                                    palette_active,
	output logic [gb_download_pkg::palette_w-1:0]    palette
);

	import gb_download_pkg::*;

	logic [ioctl_data_w-1:0] word_swapped;

	// Palette files store each word big endian
	assign word_swapped = {dl_data[7:0], dl_data[15:8]};

	////////////////////
	// Shift register
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette <= palette_default;
		end else if (dl_wr && palette_active) begin
			// Oldest word ends up at the top
			palette <= {palette[palette_w-ioctl_data_w-1:0], word_swapped};
		end
	end

endmodule

/* src/cheat_assembler.sv */
`timescale 1ns/1ps

module cheat_assembler (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic                                    dl_wr,
	input  logic [gb_download_pkg::ioctl_addr_w-1:0] dl_addr,
	input  logic [gb_download_pkg::ioctl_data_w-1:0] dl_data,
	input  logic                                    cheat_active,
	output logic [gb_download_pkg::cheat_w-1:0]      gg_code,
	output logic                                    gg_code_valid
);

	import gb_download_pkg::*;

	localparam int hi = ioctl_data_w;

	logic [cheat_strobe_bit-1:0] record;
	logic                        code_wr;

	assign code_wr = dl_wr & cheat_active;

	// Record fields, one word per offset
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_addr[cheat_offset_w-1:0])
				cheat_offset_flags_lo: record[cheat_flags_lsb +: hi]      <= dl_data;
				cheat_offset_flags_hi: record[cheat_flags_lsb + hi +: hi] <= dl_data;
				cheat_offset_addr_lo:  record[cheat_addr_lsb +: hi]       <= dl_data;
				cheat_offset_addr_hi:  record[cheat_addr_lsb + hi +: hi]  <= dl_data;
				cheat_offset_cmp_lo:   record[cheat_cmp_lsb +: hi]        <= dl_data;
				cheat_offset_cmp_hi:   record[cheat_cmp_lsb + hi +: hi]   <= dl_data;
				cheat_offset_repl_lo:  record[cheat_repl_lsb +: hi]       <= dl_data;
				cheat_offset_repl_hi:  record[cheat_repl_lsb + hi +: hi]  <= dl_data;
				default: ;
			endcase
		end
	end

	// Last word of the record clocks the code in
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gg_code_valid <= 1'b0;
		end else begin
			gg_code_valid <= code_wr && (dl_addr[cheat_offset_w-1:0] == cheat_offset_repl_hi);
		end
	end

	assign gg_code[cheat_strobe_bit]     = 1'b0;
	assign gg_code[cheat_strobe_bit-1:0] = record;

endmodule

/* src/backup_sequencer.sv */
`timescale 1ns/1ps

module backup_sequencer (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                cart_active,
	input  logic                                cart_start,
	input  logic                                cart_done,
	input  logic                                img_mounted,
	input  logic                                img_readonly,
	input  logic [63:0]                         img_size,
	input  logic                                cart_has_save,
	input  logic [gb_backup_pkg::ram_mask_w-1:0] ram_mask,
	input  logic                                cram_wr,
	input  logic                                osd_open,
	input  logic                                autosave_en,
	input  logic                                load_req,
	input  logic                                save_req,
	input  logic                                sd_ack,
	output logic [gb_backup_pkg::lba_w-1:0]      sd_lba,
	output logic                                sd_rd,
	output logic                                sd_wr,
	output logic                                bk_loading,
	output logic                                sav_pending,
	output logic                                sav_supported
);

	import gb_backup_pkg::*;

	logic bk_ena;
	logic bk_busy;
	logic load_old, save_old, auto_old, ack_old;
	logic auto_term;
	logic ack_rise, ack_fall;
	logic start_load, start_save;
	logic last_block;

	assign sav_supported = cart_has_save & bk_ena;

	always_comb begin
		auto_term  = sav_pending & osd_open & autosave_en;
		ack_rise   = sd_ack & ~ack_old;
		ack_fall   = ack_old & ~sd_ack;
		// Cartridge end load wins over a simultaneous save request
		start_load = ~bk_busy & bk_ena &
		             ((cart_done & |img_size) | (load_req & ~load_old));
		start_save = ~bk_busy & ~start_load &
		             ((bk_ena & save_req & ~save_old) | (auto_term & ~auto_old));
		last_block = sd_lba >= {{(lba_w - ram_mask_w){1'b0}}, ram_mask};
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_old <= 1'b0;
			save_old <= 1'b0;
			auto_old <= 1'b0;
			ack_old  <= 1'b0;
		end else begin
			load_old <= load_req;
			save_old <= save_req;
			auto_old <= auto_term;
			ack_old  <= sd_ack;
		end
	end

	////////////////////
	// Enable and pending save
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			if (cart_start)
				bk_ena <= 1'b0;
			// Save image is mounted before the cartridge download finishes
			if (cart_active && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (start_load || start_save)
				sav_pending <= 1'b0;
			else if (cram_wr && !osd_open && sav_supported)
				sav_pending <= 1'b1;
		end
	end

	////////////////////
	// Block loop
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
		end else begin
			// Host took the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (start_load || start_save) begin
				bk_busy    <= 1'b1;
				bk_loading <= start_load;
				sd_lba     <= '0;
				sd_rd      <= start_load;
				sd_wr      <= start_save;
			end else if (bk_busy && ack_fall) begin
				if (last_block) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + lba_w'(1);
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

/* src/backup_ram.sv */
`timescale 1ns/1ps

module backup_ram (
	input  logic                                 clk_sys,
	input  logic [gb_backup_pkg::lba_w-1:0]       sd_lba,
	input  logic [gb_backup_pkg::buff_addr_w-1:0] sd_buff_addr,
	input  logic [gb_backup_pkg::bk_data_w-1:0]   sd_buff_dout,
	input  logic                                 sd_buff_wr,
	input  logic                                 sd_ack,
	input  logic                                 cram_wr,
	input  logic [gb_backup_pkg::bk_addr_w-1:0]   cram_addr,
	input  logic [gb_backup_pkg::bk_data_w-1:0]   cram_data,
	output logic [gb_backup_pkg::bk_data_w-1:0]   sd_buff_din
);

	import gb_backup_pkg::*;

	logic [bk_data_w-1:0] mem [bk_words];
	logic [bk_addr_w-1:0] sd_addr;

	// Block page on top of the word inside the block
	assign sd_addr = {sd_lba[bk_page_w-1:0], sd_buff_addr};

	always_ff @(posedge clk_sys) begin
		if (sd_buff_wr && sd_ack)
			mem[sd_addr] <= sd_buff_dout;
		if (cram_wr)
			mem[cram_addr] <= cram_data;
		sd_buff_din <= mem[sd_addr];
	end

endmodule

/* src/gb_support_top.sv */
`timescale 1ns/1ps

module gb_support_top (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	// Host file transfer
	input  logic                                    ioctl_download,
	input  logic                                    ioctl_wr,
	input  logic [gb_download_pkg::ioctl_addr_w-1:0] ioctl_addr,
	input  logic [gb_download_pkg::ioctl_data_w-1:0] ioctl_dout,
	input  logic [gb_download_pkg::filetype_w-1:0]   filetype,
	// Cartridge and menu
	input  logic                                    cart_has_save,
	input  logic [gb_backup_pkg::ram_mask_w-1:0]     ram_mask,
	input  logic                                    cram_wr,
	input  logic [gb_backup_pkg::bk_addr_w-1:0]      cram_addr,
	input  logic [gb_backup_pkg::bk_data_w-1:0]      cram_data,
	input  logic                                    osd_open,
	input  logic                                    autosave_en,
	input  logic                                    load_req,
	input  logic                                    save_req,
	// SD image
	input  logic                                    img_mounted,
	input  logic                                    img_readonly,
	input  logic [63:0]                             img_size,
	input  logic                                    sd_ack,
	input  logic [gb_backup_pkg::buff_addr_w-1:0]    sd_buff_addr,
	input  logic [gb_backup_pkg::bk_data_w-1:0]      sd_buff_dout,
	input  logic                                    sd_buff_wr,
	output logic [gb_backup_pkg::lba_w-1:0]          sd_lba,
	output logic                                    sd_rd,
	output logic                                    sd_wr,
	output logic [gb_backup_pkg::bk_data_w-1:0]      sd_buff_din,
	// Results
	output logic [gb_download_pkg::palette_w-1:0]    palette,
	output logic [gb_download_pkg::cheat_w-1:0]      gg_code,
	output logic                                    gg_code_valid,
	output logic                                    bk_loading,
	output logic                                    sav_pending,
	output logic                                    sav_supported,
	output logic                                    led_user
);

	import gb_download_pkg::*;

	logic                    dl_wr;
	logic [ioctl_addr_w-1:0] dl_addr;
	logic [ioctl_data_w-1:0] dl_data;
	logic                    cart_active, palette_active, cheat_active;
	logic                    cart_start, cart_done;

	download_decoder u_decoder (
		.clk_sys(clk_sys), .reset(reset), .ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.filetype(filetype), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.cart_active(cart_active), .palette_active(palette_active),
		.cheat_active(cheat_active), .cart_start(cart_start), .cart_done(cart_done)
	);

	palette_loader u_palette (
		.clk_sys(clk_sys), .reset(reset), .dl_wr(dl_wr), .dl_data(dl_data),
		.palette_active(palette_active), .palette(palette)
	);

	cheat_assembler u_cheat (
		.clk_sys(clk_sys), .reset(reset), .dl_wr(dl_wr), .dl_addr(dl_addr),
		.dl_data(dl_data), .cheat_active(cheat_active), .gg_code(gg_code),
		.gg_code_valid(gg_code_valid)
	);

	backup_sequencer u_sequencer (
		.clk_sys(clk_sys), .reset(reset), .cart_active(cart_active),
		.cart_start(cart_start), .cart_done(cart_done), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .img_size(img_size), .cart_has_save(cart_has_save),
		.ram_mask(ram_mask), .cram_wr(cram_wr), .osd_open(osd_open),
		.autosave_en(autosave_en), .load_req(load_req), .save_req(save_req),
		.sd_ack(sd_ack), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.bk_loading(bk_loading), .sav_pending(sav_pending), .sav_supported(sav_supported)
	);

	backup_ram u_ram (
		.clk_sys(clk_sys), .sd_lba(sd_lba), .sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout), .sd_buff_wr(sd_buff_wr), .sd_ack(sd_ack),
		.cram_wr(cram_wr), .cram_addr(cram_addr), .cram_data(cram_data),
		.sd_buff_din(sd_buff_din)
	);

	// Activity light for downloads and unsaved data
	assign led_user = sav_pending | ioctl_download;

endmodule

/* tests/gb_support_checker.sv */
`timescale 1ns/1ps

module gb_support_checker (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                sd_rd,
	input  logic                                sd_wr,
	input  logic                                sd_ack,
	input  logic [gb_backup_pkg::lba_w-1:0]      sd_lba,
	input  logic [gb_backup_pkg::ram_mask_w-1:0] ram_mask,
	input  logic                                bk_loading,
	input  logic [gb_download_pkg::cheat_w-1:0]  gg_code,
	input  logic                                gg_code_valid
);

	import gb_download_pkg::*;

	int                 errors = 0;
	int                 valid_count = 0;
	logic [cheat_w-1:0] code_at_valid = '0;
	logic               ack_q;
	logic               loading_q;

	// Compares one value and counts a mismatch
	task automatic compare(input string name, input logic [cheat_w-1:0] got,
			input logic [cheat_w-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic protocol_error(input string msg);
		errors++;
		$display("Protocol error at %0t ns: %s", $time, msg);
	endtask

	////////////////////
	// SD handshake and strobe monitor
	////////////////////

	always @(negedge clk_sys) begin
		if (reset) begin
			ack_q     = 1'b0;
			loading_q = 1'b0;
		end else begin
			if (sd_rd && sd_wr)
				protocol_error("sd_rd and sd_wr are high together");
			// Request must be gone once the host has held sd_ack for a cycle
			if (ack_q && sd_ack && (sd_rd || sd_wr))
				protocol_error("request still high a cycle after sd_ack rose");
			if (loading_q && !bk_loading) begin
				if (sd_ack)
					protocol_error("bk_loading fell while the host still held sd_ack");
				compare("sd_lba at end of load", sd_lba, ram_mask);
			end
			if (gg_code_valid) begin
				valid_count++;
				code_at_valid = gg_code;
			end
			ack_q     = sd_ack;
			loading_q = bk_loading;
		end
	end

endmodule

/* tests/tb_gb_support.sv */
`timescale 1ns/1ps

module tb_gb_support;

	import gb_download_pkg::*;
	import gb_backup_pkg::*;

	logic                    clk_sys = 1'b0;
	logic                    reset;
	logic                    ioctl_download, ioctl_wr;
	logic [ioctl_addr_w-1:0] ioctl_addr;
	logic [ioctl_data_w-1:0] ioctl_dout;
	logic [filetype_w-1:0]   filetype;
	logic                    cart_has_save, cram_wr, osd_open, autosave_en;
	logic [ram_mask_w-1:0]   ram_mask;
	logic [bk_addr_w-1:0]    cram_addr;
	logic [bk_data_w-1:0]    cram_data, sd_buff_dout, sd_buff_din;
	logic                    load_req, save_req, img_mounted, img_readonly;
	logic [63:0]             img_size;
	logic                    sd_ack, sd_buff_wr, sd_rd, sd_wr;
	logic [buff_addr_w-1:0]  sd_buff_addr;
	logic [lba_w-1:0]        sd_lba;
	logic [palette_w-1:0]    palette;
	logic [cheat_w-1:0]      gg_code;
	logic                    gg_code_valid, bk_loading, sav_pending, sav_supported, led_user;

	logic [31:0]             testdata [0:21];
	logic [bk_data_w-1:0]    ram_model [0:bk_words-1];
	logic [31:0]             rng;
	int                      cycle_count, cycle_limit;
	int                      tests_passed, tests_failed, errors_before;

	gb_support_top dut (.*);

	gb_support_checker chk (.*);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: tests did not finish within %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Block number and word index both feed the pattern
	function automatic logic [15:0] fill_word(input logic [31:0] lba, input int idx);
		return testdata[1][15:0] ^ {lba[7:0], 8'(idx)};
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic download_word(input int offset, input logic [15:0] data);
		ioctl_addr = ioctl_addr_w'(offset);
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		next_cycle();
		ioctl_wr   = 1'b0;
		next_cycle();
	endtask

	task automatic cram_write(input logic [31:0] addr, input logic [15:0] data);
		cram_addr = addr[bk_addr_w-1:0];
		cram_data = data;
		cram_wr   = 1'b1;
		ram_model[addr[bk_addr_w-1:0]] = data;
		next_cycle();
		cram_wr   = 1'b0;
	endtask

	////////////////////
	// SD host model
	////////////////////

	task automatic serve_block(input logic is_read, input int blk);
		logic [31:0] lba;
		int          pause;
		while (!(sd_rd || sd_wr))
			next_cycle();
		chk.compare("sd_lba", sd_lba, blk);
		chk.compare("sd_rd", sd_rd, is_read);
		chk.compare("sd_wr", sd_wr, !is_read);
		chk.compare("bk_loading", bk_loading, is_read);
		lba   = sd_lba;
		rng   = xorshift(rng);
		pause = int'(rng % 8) + 1;
		repeat (pause) next_cycle();
		sd_ack = 1'b1;
		// Read data trails the buffer address by one cycle
		for (int i = 0; i <= 256; i++) begin
			if (i > 0 && !is_read)
				chk.compare("sd_buff_din", sd_buff_din,
					ram_model[{lba[bk_page_w-1:0], 8'(i - 1)}]);
			if (i < 256) begin
				sd_buff_addr = 8'(i);
				if (is_read) begin
					sd_buff_wr   = 1'b1;
					sd_buff_dout = fill_word(lba, i);
					ram_model[{lba[bk_page_w-1:0], 8'(i)}] = sd_buff_dout;
				end
			end else begin
				sd_buff_wr = 1'b0;
				sd_ack     = 1'b0;
			end
			next_cycle();
		end
	endtask

	task automatic serve_transfer(input logic is_read);
		for (int b = 0; b <= int'(ram_mask); b++)
			serve_block(is_read, b);
		next_cycle();
	endtask

	task automatic finish_test(input string name);
		if (chk.errors == errors_before) begin
			tests_passed++;
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, chk.errors - errors_before);
		end
		errors_before = chk.errors;
	endtask

	initial begin
		logic [palette_w-1:0] pal_model;
		logic [cheat_w-1:0]   code_model;
		$readmemh("tests/gb_support_testdata.hex", testdata);
		reset = 1'b1;
		{ioctl_download, ioctl_wr, ioctl_addr, ioctl_dout, filetype} = '0;
		{cart_has_save, cram_wr, cram_addr, cram_data, osd_open, autosave_en} = '0;
		{load_req, save_req, img_mounted, img_readonly, img_size} = '0;
		{sd_ack, sd_buff_addr, sd_buff_dout, sd_buff_wr} = '0;
		ram_mask      = testdata[0][ram_mask_w-1:0];
		rng           = 32'h9145_5007;
		cycle_count   = 0;
		tests_passed  = 0;
		tests_failed  = 0;
		errors_before = 0;
		// Reset and downloads take about 250 cycles and each block at most 280
		cycle_limit = 2 * (250 + 3 * (int'(ram_mask) + 1) * 280);
		repeat (16) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		next_cycle();

		// Reset state followed by a palette download
		chk.compare("palette", palette, palette_default);
		chk.compare("sd_rd", sd_rd, 0);
		chk.compare("sd_wr", sd_wr, 0);
		chk.compare("bk_loading", bk_loading, 0);
		chk.compare("sav_pending", sav_pending, 0);
		chk.compare("sav_supported", sav_supported, 0);
		chk.compare("gg_code_valid", gg_code_valid, 0);
		chk.compare("led_user", led_user, 0);
		pal_model      = palette_default;
		filetype       = ft_palette;
		ioctl_download = 1'b1;
		next_cycle();
		chk.compare("led_user", led_user, 1);
		for (int k = 0; k < 8; k++) begin
			download_word(2 * k, testdata[2 + k][15:0]);
			pal_model = {pal_model[palette_w-17:0],
				testdata[2 + k][7:0], testdata[2 + k][15:8]};
		end
		ioctl_download = 1'b0;
		repeat (2) next_cycle();
		chk.compare("palette", palette, pal_model);
		finish_test("1 palette");

		// High word sits over the low word in each cheat field
		filetype       = ft_cheat;
		ioctl_download = 1'b1;
		next_cycle();
		for (int k = 0; k < 8; k++)
			download_word(2 * k, testdata[10 + k][15:0]);
		ioctl_download = 1'b0;
		repeat (2) next_cycle();
		code_model = {1'b0, testdata[11][15:0], testdata[10][15:0], testdata[13][15:0],
			testdata[12][15:0], testdata[15][15:0], testdata[14][15:0],
			testdata[17][15:0], testdata[16][15:0]};
		chk.compare("gg_code_valid pulses", chk.valid_count, 1);
		chk.compare("gg_code", chk.code_at_valid, code_model);
		finish_test("2 cheat");

		// Cartridge download with a writable image ends in a load
		img_mounted    = 1'b1;
		img_size       = 64'((int'(ram_mask) + 1) * 512);
		cart_has_save  = 1'b1;
		filetype       = 8'h01;
		ioctl_download = 1'b1;
		next_cycle();
		for (int k = 0; k < 4; k++)
			download_word(2 * k, 16'(k));
		ioctl_download = 1'b0;
		serve_transfer(1'b1);
		chk.compare("bk_loading", bk_loading, 0);
		chk.compare("sav_supported", sav_supported, 1);
		finish_test("3 autoload");

		// Manual save returns loaded words with the cartridge writes
		cram_write(testdata[18], testdata[19][15:0]);
		cram_write(testdata[20], testdata[21][15:0]);
		save_req = 1'b1;
		next_cycle();
		save_req = 1'b0;
		serve_transfer(1'b0);
		chk.compare("sav_pending", sav_pending, 0);
		finish_test("4 save");

		// Pending flag and autosave on menu open
		autosave_en = 1'b1;
		cram_write(testdata[18], ~testdata[19][15:0]);
		chk.compare("sav_pending", sav_pending, 1);
		chk.compare("led_user", led_user, 1);
		osd_open = 1'b1;
		serve_transfer(1'b0);
		chk.compare("sav_pending", sav_pending, 0);
		osd_open    = 1'b0;
		autosave_en = 1'b0;
		finish_test("5 autosave");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* tests/gb_support_testdata.hex */
// Word 0 last block index, word 1 fill seed, words 2-9 palette, words 10-17 cheat offsets 0-14
// Words 18-21 two save RAM writes, each a word address followed by its data
00000002
00005A3C
00001F7C
0000E003
00004A29
0000B5D6
000000FF
0000FF00
00003C81
0000C3E7
00000001
00000000
0000C123
00000000
000000AB
00000000
000000CD
00000012
00000105
0000BEEF
00000280
0000C0DE

/* src.f */
src/gb_download_pkg.sv
src/gb_backup_pkg.sv
src/download_decoder.sv
src/palette_loader.sv
src/cheat_assembler.sv
src/backup_sequencer.sv
src/backup_ram.sv
src/gb_support_top.sv
tests/gb_support_checker.sv
tests/tb_gb_support.sv
